/* Bender.yml */
package:
  name: ecc_point_mul

sources:
  - verilog/ecc_pkg.sv
  - verilog/ecc_key_scanner.sv
  - verilog/ecc_step_sequencer.sv
  - verilog/ecc_work_regs.sv
  - verilog/ecc_point_mul.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/ecc_point_mul_tb.sv

/* include/ecc_tb_model.svh */
`ifndef ECC_TB_MODEL_SVH
`define ECC_TB_MODEL_SVH

localparam logic [63:0] TEST_PRIME = 64'd4294967291;  // largest 32 bit prime

logic [31:0] lfsr_state = 32'h2ad2;
fau_req_t    exp_q [$];

// x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

function automatic field_t rand_field();
    return field_t'({32'b0, take_bits(32)} % TEST_PRIME);
endfunction

function automatic field_t mod_add(input field_t a, input field_t b);
    return field_t'(({32'b0, a} + {32'b0, b}) % TEST_PRIME);
endfunction

function automatic field_t mod_sub(input field_t a, input field_t b);
    return field_t'(({32'b0, a} + TEST_PRIME - {32'b0, b}) % TEST_PRIME);
endfunction

function automatic field_t mod_mul(input field_t a, input field_t b);
    return field_t'(({32'b0, a} * {32'b0, b}) % TEST_PRIME);
endfunction

// fermat inverse, zero divisor gives zero
function automatic field_t mod_div(input field_t a, input field_t b);
    field_t acc;
    field_t sq;
    field_t e;
    acc = 32'd1;
    sq  = b;
    e   = field_t'(TEST_PRIME - 64'd2);
    for (int i = 0; i < DATA_W; i++)
    begin
        if (e[i])
            acc = mod_mul(acc, sq);
        sq = mod_mul(sq, sq);
    end
    return (b == '0) ? '0 : mod_mul(a, acc);
endfunction

function automatic field_t fau_compute(input fau_op_e op, input field_t a, input field_t b);
    case (op)
        FAU_ADD: return mod_add(a, b);
        FAU_SUB: return mod_sub(a, b);
        FAU_MUL: return mod_mul(a, b);
        default: return mod_div(a, b);
    endcase
endfunction

// queue the request, hand back what the unit will answer
function automatic field_t issue(input fau_op_e op, input field_t a, input field_t b);
    exp_q.push_back('{op: op, opa: a, opb: b});
    return fau_compute(op, a, b);
endfunction

function automatic void build_stream(input logic [TB_KEY_BITS-1:0] key, input point_t p,
                                     input field_t a);
    field_t x1, y1, r1, r2, x3;
    exp_q.delete();
    x1 = p.x;
    y1 = p.y;
    for (int i = TB_KEY_BITS - 2; i >= 0; i--)
    begin
        r1 = issue(FAU_MUL, x1, x1);
        r2 = issue(FAU_ADD, r1, r1);
        r1 = issue(FAU_ADD, r1, r2);
        r1 = issue(FAU_ADD, r1, a);
        r2 = issue(FAU_ADD, y1, y1);
        r1 = issue(FAU_DIV, r1, r2);
        r2 = issue(FAU_MUL, r1, r1);
        r2 = issue(FAU_SUB, r2, x1);
        x3 = issue(FAU_SUB, r2, x1);
        r2 = issue(FAU_SUB, x1, x3);
        r2 = issue(FAU_MUL, r1, r2);
        y1 = issue(FAU_SUB, r2, y1);
        x1 = x3;
        if (key[i])
        begin
            r1 = issue(FAU_SUB, p.x, x1);
            r2 = issue(FAU_SUB, p.y, y1);
            r1 = issue(FAU_DIV, r2, r1);
            r2 = issue(FAU_MUL, r1, r1);
            r2 = issue(FAU_SUB, r2, x1);
            x3 = issue(FAU_SUB, r2, p.x);
            r2 = issue(FAU_SUB, x1, x3);
            r2 = issue(FAU_MUL, r1, r2);
            y1 = issue(FAU_SUB, r2, y1);
            x1 = x3;
        end
    end
endfunction

// textbook affine formulas, top key bit taken as one
function automatic point_t ref_multiply(input logic [TB_KEY_BITS-1:0] key, input point_t p,
                                        input field_t a);
    point_t q;
    field_t lam;
    field_t xn;
    q = p;
    for (int i = TB_KEY_BITS - 2; i >= 0; i--)
    begin
        lam = mod_div(mod_add(mod_mul(32'd3, mod_mul(q.x, q.x)), a), mod_add(q.y, q.y));
        xn  = mod_sub(mod_mul(lam, lam), mod_add(q.x, q.x));
        q   = '{x: xn, y: mod_sub(mod_mul(lam, mod_sub(q.x, xn)), q.y)};
        if (key[i])
        begin
            lam = mod_div(mod_sub(p.y, q.y), mod_sub(p.x, q.x));
            xn  = mod_sub(mod_sub(mod_mul(lam, lam), q.x), p.x);
            q   = '{x: xn, y: mod_sub(mod_mul(lam, mod_sub(q.x, xn)), q.y)};
        end
    end
    return q;
endfunction

`endif

/* bench/ecc_point_mul_tb.sv */
module ecc_point_mul_tb;
    import ecc_pkg::*;

    localparam int TB_KEY_BITS  = 8;
    localparam int DONE_TIMEOUT = 5000;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_start;
    logic [TB_KEY_BITS-1:0] i_key;
    point_t                 i_base;
    field_t                 i_curve_a;
    logic                   o_fau_req_valid;
    fau_req_t               o_fau_req;
    logic                   i_fau_done;
    field_t                 i_fau_result;
    logic                   o_done;
    point_t                 o_result;

    string test_name;
    logic  fixed_lat;
    int    cycle      = 0;
    int    done_count = 0;
    int    run_count  = 0;
    int    req_count;
    int    start_cycle;
    int    prev_req_cycle;
    int    last_done_cycle;

    `include "ecc_tb_model.svh"

    ecc_point_mul #(
        .KEY_BITS        (TB_KEY_BITS)
    ) i_dut (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_key           (i_key),
        .i_base          (i_base),
        .i_curve_a       (i_curve_a),
        .o_fau_req_valid (o_fau_req_valid),
        .o_fau_req       (o_fau_req),
        .i_fau_done      (i_fau_done),
        .i_fau_result    (i_fau_result),
        .o_done          (o_done),
        .o_result        (o_result)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycle <= cycle + 1;
        if (o_done === 1'b1)
            done_count <= done_count + 1;
    end

    task automatic abort_on_error(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [65:0] expected,
                               input logic [65:0] actual);
        assert (expected === actual)
        else abort_on_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                      test_name, what, expected, actual));
    endtask

    // arithmetic unit model with at most one request outstanding
    always
    begin : fau_responder
        fau_req_t req;
        int       lat;
        @(posedge i_clk);
        if (o_fau_req_valid === 1'b1)
        begin
            req = o_fau_req;
            assert (exp_q.size() > 0)
            else abort_on_error({test_name, ": more requests than the step lists give"});
            check_value("request", exp_q.pop_front(), req);
            if (fixed_lat)
                check_value("request cycle",
                            (req_count == 0) ? start_cycle + 1 : prev_req_cycle + 2, cycle);
            prev_req_cycle = cycle;
            req_count++;
            lat = fixed_lat ? 1 : int'(take_bits(2)) + 1;
            repeat (lat - 1)
            begin
                @(posedge i_clk);
                assert (o_fau_req_valid !== 1'b1)
                else abort_on_error({test_name, ": new request while one is outstanding"});
            end
            #10;
            i_fau_done   = 1'b1;
            i_fau_result = fau_compute(req.op, req.opa, req.opb);
            @(posedge i_clk);
            last_done_cycle = cycle;
            #10;
            i_fau_done = 1'b0;
        end
    end

    // entered and left 10 units after a rising edge
    task automatic run_test(input string name, input logic [TB_KEY_BITS-1:0] key,
                            input logic fixed, input logic busy_start);
        point_t base;
        point_t alt_base;
        point_t expected;
        field_t a;
        int     exp_count;
        int     done_cycle;
        logic   got_done;
        test_name = name;
        base      = '{x: rand_field(), y: rand_field()};
        a         = rand_field();
        alt_base  = '{x: rand_field(), y: rand_field()};
        expected  = ref_multiply(key, base, a);
        exp_count = 12 * (TB_KEY_BITS - 1) + 9 * $countones(key[TB_KEY_BITS-2:0]);
        build_stream(key, base, a);
        fixed_lat = fixed;
        req_count = 0;
        i_start   = 1'b1;
        i_key     = key;
        i_base    = base;
        i_curve_a = a;
        @(posedge i_clk);
        start_cycle = cycle;
        run_count++;
        #10;
        i_start  = 1'b0;
        got_done = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !got_done; n++)
        begin
            @(posedge i_clk);
            if (o_done === 1'b1)
            begin
                got_done   = 1'b1;
                done_cycle = cycle;
            end
            else if (busy_start && (n == 20 || n == 21))
            begin
                #10;
                i_start   = (n == 20);  // must be ignored mid-run
                i_key     = ~key;
                i_base    = alt_base;
                i_curve_a = alt_base.x;
            end
        end
        assert (got_done)
        else abort_on_error({name, ": timed out waiting for o_done"});
        check_value("result", expected, o_result);
        check_value("request count", exp_count, req_count);
        check_value("requests left", 0, exp_q.size());
        if (fixed)
            check_value("done cycle", last_done_cycle + 1, done_cycle);
        @(posedge i_clk);
        #10;
        check_value("done pulses", run_count, done_count);
    endtask

    initial
    begin
        i_clk        = 1'b0;
        i_reset      = 1'b1;
        i_start      = 1'b0;
        i_key        = '0;
        i_base       = '0;
        i_curve_a    = '0;
        i_fau_done   = 1'b0;
        i_fau_result = '0;
        fixed_lat    = 1'b0;
        test_name    = "reset";
        repeat (4) @(posedge i_clk);
        #10;
        i_reset = 1'b0;
        repeat (5)
        begin
            @(posedge i_clk);
            assert (o_fau_req_valid === 1'b0 && o_done === 1'b0)
            else abort_on_error("request or done strobe seen before any start");
        end
        #10;
        run_test("lower_bits_clear", {1'b1, {(TB_KEY_BITS - 1){1'b0}}}, 1'b0, 1'b0);
        run_test("all_bits_set", '1, 1'b0, 1'b0);
        run_test("fixed_latency", TB_KEY_BITS'(take_bits(TB_KEY_BITS)), 1'b1, 1'b0);
        run_test("start_while_busy", TB_KEY_BITS'(take_bits(TB_KEY_BITS)), 1'b0, 1'b1);
        for (int k = 0; k < 4; k++)
            run_test($sformatf("random_%0d", k), TB_KEY_BITS'(take_bits(TB_KEY_BITS)),
                     1'b0, 1'b0);
        repeat (10) @(posedge i_clk);  // idle tail so a late o_done is still counted
        #10;
        if (done_count == run_count)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            abort_on_error("o_done pulse count differs from accepted starts");
        end
    end

endmodule

/* project.f */
+incdir+include
verilog/ecc_pkg.sv
verilog/ecc_key_scanner.sv
verilog/ecc_step_sequencer.sv
verilog/ecc_work_regs.sv
verilog/ecc_point_mul.sv
bench/ecc_point_mul_tb.sv

/* verilog/ecc_key_scanner.sv */
module ecc_key_scanner #(
    parameter int KEY_BITS = ecc_pkg::KEY_BITS_DEF
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_start,
    input  logic [KEY_BITS-1:0] i_key,
    input  logic                i_bit_next,
    output logic                o_bit,
    output logic                o_last_bit
);

    localparam int IDX_W = (KEY_BITS > 2) ? $clog2(KEY_BITS) : 1;

    logic [KEY_BITS-1:0] key_q;
    logic [IDX_W-1:0]    idx_q;

    // top bit is the implied leading one, scanning starts below it
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            idx_q <= '0;
        end
        else if (i_start)
        begin
            idx_q <= IDX_W'(KEY_BITS - 2);
        end
        else if (i_bit_next && (idx_q != '0))
        begin
            idx_q <= idx_q - 1'b1;  // high to low
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            key_q <= i_key;
        end
    end

    assign o_bit      = key_q[idx_q];
    assign o_last_bit = (idx_q == '0);

endmodule

/* verilog/ecc_pkg.sv */
package ecc_pkg;

    localparam int DATA_W       = 32;
    localparam int KEY_BITS_DEF = 32;

    typedef logic [DATA_W-1:0] field_t;

    typedef struct packed {
        field_t x;
        field_t y;
    } point_t;

    // field arithmetic unit opcodes
    typedef enum logic [1:0] {
        FAU_ADD = 2'd0,
        FAU_SUB = 2'd1,
        FAU_MUL = 2'd2,
        FAU_DIV = 2'd3
    } fau_op_e;

    typedef struct packed {
        fau_op_e op;
        field_t  opa;
        field_t  opb;
    } fau_req_t;

    // doubling and addition steps are each numbered consecutively
    typedef enum logic [4:0] {
        ST_IDLE = 5'd0,
        DBL_1   = 5'd1,
        DBL_2   = 5'd2,
        DBL_3   = 5'd3,
        DBL_4   = 5'd4,
        DBL_5   = 5'd5,
        DBL_6   = 5'd6,
        DBL_7   = 5'd7,
        DBL_8   = 5'd8,
        DBL_9   = 5'd9,
        DBL_10  = 5'd10,
        DBL_11  = 5'd11,
        DBL_12  = 5'd12,
        ADD_1   = 5'd13,
        ADD_2   = 5'd14,
        ADD_3   = 5'd15,
        ADD_4   = 5'd16,
        ADD_5   = 5'd17,
        ADD_6   = 5'd18,
        ADD_7   = 5'd19,
        ADD_8   = 5'd20,
        ADD_9   = 5'd21
    } step_e;

endpackage

/* verilog/ecc_point_mul.sv */
module ecc_point_mul #(
    parameter int KEY_BITS = ecc_pkg::KEY_BITS_DEF
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_start,
    input  logic [KEY_BITS-1:0] i_key,
    input  ecc_pkg::point_t    i_base,
    input  ecc_pkg::field_t    i_curve_a,
    output logic               o_fau_req_valid,
    output ecc_pkg::fau_req_t  o_fau_req,
    input  logic               i_fau_done,
    input  ecc_pkg::field_t    i_fau_result,
    output logic               o_done,
    output ecc_pkg::point_t    o_result
);
    import ecc_pkg::*;

    logic    key_bit;
    logic    last_bit;
    logic    bit_next;
    logic    busy;
    logic    wr_en;
    logic    start_ok;
    step_e   step;
    fau_op_e fau_op;
    field_t  opa;
    field_t  opb;

    assign start_ok  = i_start && !busy;  // scanner must not reload mid-run
    assign o_fau_req = '{op: fau_op, opa: opa, opb: opb};

    ecc_key_scanner #(
        .KEY_BITS   (KEY_BITS)
    ) u_scanner (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (start_ok),
        .i_key      (i_key),
        .i_bit_next (bit_next),
        .o_bit      (key_bit),
        .o_last_bit (last_bit)
    );

    ecc_step_sequencer u_sequencer (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_bit           (key_bit),
        .i_last_bit      (last_bit),
        .i_fau_done      (i_fau_done),
        .o_fau_req_valid (o_fau_req_valid),
        .o_fau_op        (fau_op),
        .o_step          (step),
        .o_wr_en         (wr_en),
        .o_bit_next      (bit_next),
        .o_done          (o_done),
        .o_busy          (busy)
    );

    ecc_work_regs u_work_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_busy       (busy),
        .i_base       (i_base),
        .i_curve_a    (i_curve_a),
        .i_step       (step),
        .i_wr_en      (wr_en),
        .i_fau_result (i_fau_result),
        .o_opa        (opa),
        .o_opb        (opb),
        .o_result     (o_result)
    );

endmodule

/* verilog/ecc_step_sequencer.sv */
module ecc_step_sequencer (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_start,
    input  logic             i_bit,
    input  logic             i_last_bit,
    input  logic             i_fau_done,
    output logic             o_fau_req_valid,
    output ecc_pkg::fau_op_e o_fau_op,
    output ecc_pkg::step_e   o_step,
    output logic             o_wr_en,
    output logic             o_bit_next,
    output logic             o_done,
    output logic             o_busy
);
    import ecc_pkg::*;

    step_e state;
    step_e state_next;
    logic  req_q;
    logic  done_q;
    logic  op_end;
    logic  take_add;
    logic  bit_end;

    assign op_end   = (state == DBL_12) || (state == ADD_9);
    assign take_add = (state == DBL_12) && i_bit;       // set bit adds P after doubling
    assign bit_end  = i_fau_done && op_end && !take_add;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (i_start)
                begin
                    state_next = DBL_1;
                end
            end
            default:
            begin
                if (i_fau_done)
                begin
                    if (take_add)
                    begin
                        state_next = ADD_1;
                    end
                    else if (op_end)
                    begin
                        state_next = i_last_bit ? ST_IDLE : DBL_1;
                    end
                    else
                    begin
                        state_next = step_e'(state + 5'd1);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= ST_IDLE;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            // one strobe on entry to every step
            req_q  <= (state == ST_IDLE) ? i_start : (i_fau_done && state_next != ST_IDLE);
            done_q <= bit_end && i_last_bit;
        end
    end

    always_comb
    begin
        case (state)
            DBL_1, DBL_7, DBL_11, ADD_4, ADD_8:
                o_fau_op = FAU_MUL;
            DBL_6, ADD_3:
                o_fau_op = FAU_DIV;
            DBL_8, DBL_9, DBL_10, DBL_12, ADD_1, ADD_2, ADD_5, ADD_6, ADD_7, ADD_9:
                o_fau_op = FAU_SUB;
            default:
                o_fau_op = FAU_ADD;  // dbl 2 to 5, idle
        endcase
    end

    assign o_fau_req_valid = req_q;
    assign o_wr_en         = i_fau_done && (state != ST_IDLE);
    assign o_bit_next      = bit_end && !i_last_bit;
    assign o_done          = done_q;
    assign o_busy          = (state != ST_IDLE);
    assign o_step          = state;

endmodule

/* verilog/ecc_work_regs.sv */
module ecc_work_regs (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  logic            i_busy,
    input  ecc_pkg::point_t i_base,
    input  ecc_pkg::field_t i_curve_a,
    input  ecc_pkg::step_e  i_step,
    input  logic            i_wr_en,
    input  ecc_pkg::field_t i_fau_result,
    output ecc_pkg::field_t o_opa,
    output ecc_pkg::field_t o_opb,
    output ecc_pkg::point_t o_result
);
    import ecc_pkg::*;

    typedef enum logic [2:0] {
        SRC_X1, SRC_Y1, SRC_X2, SRC_Y2, SRC_R1, SRC_R2, SRC_X3, SRC_A
    } src_e;

    typedef enum logic [2:0] {
        DST_NONE, DST_R1, DST_R2, DST_X3, DST_ACC
    } dst_e;

    point_t acc;
    point_t base;
    field_t curve_a;
    field_t r1;
    field_t r2;
    field_t x3;
    field_t src_val [0:7];
    src_e   sel_a;
    src_e   sel_b;
    dst_e   dst;
    logic   load;

    assign load = i_start && !i_busy;

    always_comb
    begin
        case (i_step)
            DBL_1:   {sel_a, sel_b, dst} = {SRC_X1, SRC_X1, DST_R1};
            DBL_2:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R1, DST_R2};
            DBL_3:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R2, DST_R1};
            DBL_4:   {sel_a, sel_b, dst} = {SRC_R1, SRC_A,  DST_R1};
            DBL_5:   {sel_a, sel_b, dst} = {SRC_Y1, SRC_Y1, DST_R2};  // 2y
            DBL_6:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R2, DST_R1};  // lambda
            DBL_7:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R1, DST_R2};
            DBL_8:   {sel_a, sel_b, dst} = {SRC_R2, SRC_X1, DST_R2};
            DBL_9:   {sel_a, sel_b, dst} = {SRC_R2, SRC_X1, DST_X3};
            DBL_10:  {sel_a, sel_b, dst} = {SRC_X1, SRC_X3, DST_R2};
            DBL_11:  {sel_a, sel_b, dst} = {SRC_R1, SRC_R2, DST_R2};
            DBL_12:  {sel_a, sel_b, dst} = {SRC_R2, SRC_Y1, DST_ACC};
            ADD_1:   {sel_a, sel_b, dst} = {SRC_X2, SRC_X1, DST_R1};
            ADD_2:   {sel_a, sel_b, dst} = {SRC_Y2, SRC_Y1, DST_R2};
            ADD_3:   {sel_a, sel_b, dst} = {SRC_R2, SRC_R1, DST_R1};  // lambda
            ADD_4:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R1, DST_R2};
            ADD_5:   {sel_a, sel_b, dst} = {SRC_R2, SRC_X1, DST_R2};
            ADD_6:   {sel_a, sel_b, dst} = {SRC_R2, SRC_X2, DST_X3};
            ADD_7:   {sel_a, sel_b, dst} = {SRC_X1, SRC_X3, DST_R2};
            ADD_8:   {sel_a, sel_b, dst} = {SRC_R1, SRC_R2, DST_R2};
            ADD_9:   {sel_a, sel_b, dst} = {SRC_R2, SRC_Y1, DST_ACC};
            default: {sel_a, sel_b, dst} = {SRC_X1, SRC_X1, DST_NONE};
        endcase
    end

    assign src_val[SRC_X1] = acc.x;
    assign src_val[SRC_Y1] = acc.y;
    assign src_val[SRC_X2] = base.x;
    assign src_val[SRC_Y2] = base.y;
    assign src_val[SRC_R1] = r1;
    assign src_val[SRC_R2] = r2;
    assign src_val[SRC_X3] = x3;
    assign src_val[SRC_A]  = curve_a;

    assign o_opa = src_val[sel_a];
    assign o_opb = src_val[sel_b];

    // accumulator starts at P for the implied leading one
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            acc <= '0;
        end
        else if (load)
        begin
            acc <= i_base;
        end
        else if (i_wr_en && (dst == DST_ACC))
        begin
            acc <= '{x: x3, y: i_fau_result};  // y3 lands with x3
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load)
        begin
            base    <= i_base;
            curve_a <= i_curve_a;
        end
        if (i_wr_en)
        begin
            case (dst)
                DST_R1:  r1 <= i_fau_result;
                DST_R2:  r2 <= i_fau_result;
                DST_X3:  x3 <= i_fau_result;
                default: ;
            endcase
        end
    end

    assign o_result = acc;

endmodule
